/* design/desc_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module desc_ram import rx_pkg::*; #(
	parameter int DESC_WORDS = 256
) (
	input  wire         aclk,
	input  wire         aresetn,

	// burst slave side
	input  axi_ar_t     ar,
	output logic        ar_ready,
	output axi_r_t      r,
	input  wire         r_ready,
	input  axi_aw_t     aw,
	output logic        aw_ready,
	input  axi_w_t      w,
	output logic        w_ready,
	output axi_b_t      b,
	input  wire         b_ready,

	// host load / inspect port
	input  wire         host_wr_valid,
	input  wire  [15:0] host_wr_addr,
	input  wire  [31:0] host_wr_data,
	input  wire  [15:0] host_rd_addr,
	output logic [31:0] host_rd_data
);

	localparam int IDX_W = $clog2(DESC_WORDS);

	logic [31:0] mem [DESC_WORDS];

	// read burst state
	logic        rd_valid;
	logic        rd_last;
	logic [7:0]  rd_left;
	logic [15:0] rd_addr;
	logic [3:0]  rd_id;
	logic [31:0] rd_data;

	// write burst state
	logic        wr_act;
	logic [15:0] wr_addr;
	logic [3:0]  wr_id;
	logic        b_valid;

	logic        ar_take;
	logic        r_take;
	logic        w_take;

	assign ar_take = ar.valid && ar_ready;
	assign r_take  = rd_valid && r_ready;
	assign w_take  = w.valid && w_ready;

	//////////////////////////////////////////////////
	// read channel
	//////////////////////////////////////////////////

	// one burst at a time
	assign ar_ready = !rd_valid;
	assign r = '{id: rd_id, data: rd_data, resp: RESP_OKAY, last: rd_last, valid: rd_valid};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_valid <= 1'b0;
			rd_last  <= 1'b0;
			rd_left  <= '0;
		end else if (ar_take) begin
			rd_valid <= 1'b1;
			rd_last  <= (ar.len == 8'd0);
			rd_left  <= ar.len;
		end else if (r_take) begin
			// drop valid after last beat
			rd_valid <= !rd_last;
			rd_last  <= (rd_left == 8'd1);
			rd_left  <= rd_left - 8'd1;
		end
	end

	// beat data and next address
	always_ff @(posedge aclk) begin
		if (ar_take) begin
			rd_id   <= ar.id;
			rd_data <= mem[ar.addr[IDX_W+1:2]];
			rd_addr <= ar.addr + 16'd4;
		end else if (r_take && !rd_last) begin
			rd_data <= mem[rd_addr[IDX_W+1:2]];
			rd_addr <= rd_addr + 16'd4;
		end
	end

	//////////////////////////////////////////////////
	// write channel
	//////////////////////////////////////////////////

	assign aw_ready = !wr_act && !b_valid;
	assign w_ready  = wr_act;
	assign b = '{id: wr_id, resp: RESP_OKAY, valid: b_valid};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_act  <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			if (aw.valid && aw_ready)
				wr_act <= 1'b1;
			else if (w_take && w.last)
				wr_act <= 1'b0;
			// response one cycle after last beat
			if (w_take && w.last)
				b_valid <= 1'b1;
			else if (b_valid && b_ready)
				b_valid <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (aw.valid && aw_ready) begin
			wr_addr <= aw.addr;
			wr_id   <= aw.id;
		end else if (w_take) begin
			wr_addr <= wr_addr + 16'd4;
		end
	end

	// burst bytes first, host write last so it wins
	always_ff @(posedge aclk) begin
		if (w_take) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_addr[IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
		if (host_wr_valid)
			mem[host_wr_addr[IDX_W+1:2]] <= host_wr_data;
	end

	// host read, one cycle latency
	always_ff @(posedge aclk) begin
		host_rd_data <= mem[host_rd_addr[IDX_W+1:2]];
	end

endmodule

`default_nettype wire

/* design/frame_store.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_store import rx_pkg::*; #(
	parameter int FRAME_DEPTH = 8
) (
	input  wire        aclk,
	input  wire        aresetn,

	input  frame_rec_t frame_in,
	input  wire        frame_valid,
	output logic       frame_ready,

	input  frm_cmd_t   frm_cmd,
	input  wire        frm_cmd_valid,
	output logic       frm_cmd_ready,

	output frm_rsp_t   frm_rsp,
	output logic       frm_rsp_valid,
	input  wire        frm_rsp_ready
);

	localparam int PTR_W = (FRAME_DEPTH > 1) ? $clog2(FRAME_DEPTH) : 1;

	frame_rec_t fifo [FRAME_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	// bytes of the head frame still to place
	logic [15:0] rem_len;
	logic        rem_valid;

	// command waiting for a frame
	logic        cmd_pend;
	logic [15:0] pend_len;

	logic        push;
	logic        take;
	logic        serve;
	logic        pop;
	logic        fits;
	logic [15:0] head_len;
	logic [15:0] cur_len;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FRAME_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign frame_ready   = (count != (PTR_W+1)'(FRAME_DEPTH));
	assign push          = frame_valid && frame_ready;
	assign frm_cmd_ready = !cmd_pend && !frm_rsp_valid;
	assign take          = frm_cmd_valid && frm_cmd_ready;

	// answer a fresh or parked command once a frame is queued
	assign cur_len  = cmd_pend ? pend_len : frm_cmd.buf_len;
	assign serve    = (take || cmd_pend) && (count != '0);
	assign head_len = rem_valid ? rem_len : fifo[rd_ptr].length;
	assign fits     = (head_len <= cur_len);
	assign pop      = serve && fits;

	//////////////////////////////////////////////////
	// record queue
	//////////////////////////////////////////////////

	always_ff @(posedge aclk) begin
		if (push)
			fifo[wr_ptr] <= frame_in;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// command / response
	//////////////////////////////////////////////////

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cmd_pend      <= 1'b0;
			rem_valid     <= 1'b0;
			frm_rsp_valid <= 1'b0;
		end else begin
			if (serve) begin
				cmd_pend      <= 1'b0;
				frm_rsp_valid <= 1'b1;
				// split frames keep their remainder at the head
				rem_valid     <= !fits;
			end else begin
				if (take)
					cmd_pend <= 1'b1;
				if (frm_rsp_valid && frm_rsp_ready)
					frm_rsp_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (take)
			pend_len <= frm_cmd.buf_len;
		if (serve) begin
			frm_rsp.wb_len <= fits ? head_len : cur_len;
			frm_rsp.eop    <= fits;
			frm_rsp.errors <= fits ? fifo[rd_ptr].errors : 8'd0;
			rem_len        <= head_len - cur_len;
		end
	end

	// full queue takes nothing until a record leaves
	a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
		(count == (PTR_W+1)'(FRAME_DEPTH) && !pop) |=>
			(count == (PTR_W+1)'(FRAME_DEPTH) && wr_ptr == $past(wr_ptr)));

	// a response always comes from a queued frame
	a_no_rsp_empty: assert property (@(posedge aclk) disable iff (!aresetn)
		$rose(frm_rsp_valid) |-> ($past(count) != '0));

endmodule

`default_nettype wire

/* design/rx_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_engine import rx_pkg::*; #(
	parameter int BUF_BYTES = 2048
) (
	input  wire         aclk,
	input  wire         aresetn,

	// descriptor command
	input  wire  [15:0] cmd_addr,
	input  wire         cmd_valid,
	output logic        cmd_ready,

	// completion report
	output stat_t       stat,
	input  wire         stat_ready,

	// burst master to descriptor ram
	output axi_ar_t     ar,
	input  wire         ar_ready,
	input  axi_r_t      r,
	output logic        r_ready,
	output axi_aw_t     aw,
	input  wire         aw_ready,
	output axi_w_t      w,
	input  wire         w_ready,
	input  axi_b_t      b,
	output logic        b_ready,

	// frame store
	output frm_cmd_t    frm_cmd,
	output logic        frm_cmd_valid,
	input  wire         frm_cmd_ready,
	input  frm_rsp_t    frm_rsp,
	input  wire         frm_rsp_valid,
	output logic        frm_rsp_ready
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_FETCH_ADDR,
		S_FETCH_DATA,
		S_NULL_CHECK,
		S_FRM_CMD,
		S_FRM_WAIT,
		S_WR_ADDR,
		S_WR_DW2,
		S_WR_DW3,
		S_WR_RESP,
		S_REPORT
	} state_t;

	state_t state;
	state_t state_next;

	// latched descriptor address and fetched words
	logic [15:0] cur_addr;
	rx_desc_u    desc;
	logic        fetch_hi;

	// write-back fields
	logic [15:0] wb_len;
	logic        wb_eop;
	logic [7:0]  wb_err;
	logic        null_buf;
	logic [7:0]  wb_status;
	rx_desc_u    wb_desc;

	logic        null_desc;

	assign null_desc = (desc.rd.buf_addr == 64'd0);

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:
				if (cmd_valid)
					state_next = S_FETCH_ADDR;
			S_FETCH_ADDR:
				if (ar_ready)
					state_next = S_FETCH_DATA;
			S_FETCH_DATA:
				if (r.valid && r.last)
					state_next = S_NULL_CHECK;
			// null buffer skips the frame store
			S_NULL_CHECK:
				state_next = null_desc ? S_WR_ADDR : S_FRM_CMD;
			S_FRM_CMD:
				if (frm_cmd_ready)
					state_next = S_FRM_WAIT;
			S_FRM_WAIT:
				if (frm_rsp_valid)
					state_next = S_WR_ADDR;
			S_WR_ADDR:
				if (aw_ready)
					state_next = S_WR_DW2;
			S_WR_DW2:
				if (w_ready)
					state_next = S_WR_DW3;
			S_WR_DW3:
				if (w_ready)
					state_next = S_WR_RESP;
			S_WR_RESP:
				if (b.valid)
					state_next = S_REPORT;
			S_REPORT:
				if (stat_ready)
					state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// fetch and frame result capture
	//////////////////////////////////////////////////

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			fetch_hi <= 1'b0;
		else if (state == S_FETCH_ADDR)
			fetch_hi <= 1'b0;
		else if (r.valid && r_ready)
			fetch_hi <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (cmd_valid && cmd_ready) begin
			cur_addr <= cmd_addr;
			desc     <= '0;
		end
		// dw0 then dw1 into the buffer address
		if (r.valid && r_ready) begin
			if (fetch_hi)
				desc.rd.buf_addr[63:32] <= r.data;
			else
				desc.rd.buf_addr[31:0] <= r.data;
		end
		if (state == S_NULL_CHECK && null_desc) begin
			wb_len   <= 16'd0;
			wb_eop   <= 1'b0;
			wb_err   <= 8'd0;
			null_buf <= 1'b1;
		end
		if (frm_rsp_valid && frm_rsp_ready) begin
			wb_len   <= frm_rsp.wb_len;
			wb_eop   <= frm_rsp.eop;
			wb_err   <= frm_rsp.errors;
			null_buf <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// write-back view
	//////////////////////////////////////////////////

	always_comb begin
		wb_status          = 8'd0;
		wb_status[STA_DD]  = 1'b1;
		wb_status[STA_EOP] = wb_eop;
		wb_desc.wb.buf_addr = desc.rd.buf_addr;
		wb_desc.wb.length   = wb_len;
		wb_desc.wb.csum     = 16'd0;
		wb_desc.wb.status   = wb_status;
		// errors only land on the last buffer of a frame
		wb_desc.wb.errors   = wb_eop ? wb_err : 8'd0;
		wb_desc.wb.special  = 16'd0;
	end

	//////////////////////////////////////////////////
	// channel outputs, all decoded from state
	//////////////////////////////////////////////////

	assign cmd_ready = (state == S_IDLE);

	// two-beat fetch of dw0/dw1
	assign ar = '{id: 4'd0, addr: cur_addr, len: 8'd1, valid: (state == S_FETCH_ADDR)};
	assign r_ready = (state == S_FETCH_DATA);

	// two-beat write of dw2/dw3 at offset 8
	assign aw = '{id: 4'd0, addr: cur_addr + 16'd8, len: 8'd1, valid: (state == S_WR_ADDR)};
	assign w.data  = (state == S_WR_DW3) ? wb_desc[127:96] : wb_desc[95:64];
	assign w.strb  = 4'hf;
	assign w.last  = (state == S_WR_DW3);
	assign w.valid = (state == S_WR_DW2) || (state == S_WR_DW3);
	assign b_ready = (state == S_WR_RESP);

	assign frm_cmd.buf_addr = desc.rd.buf_addr[15:0];
	assign frm_cmd.buf_len  = 16'(BUF_BYTES);
	assign frm_cmd_valid    = (state == S_FRM_CMD);
	assign frm_rsp_ready    = (state == S_FRM_WAIT);

	assign stat = '{desc_addr: cur_addr, eop: wb_eop, null_buf: null_buf,
		valid: (state == S_REPORT)};

	// report holds under back-pressure
	a_stat_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		(stat.valid && !stat_ready) |=> $stable(stat));

	// ram presents r beats only while this engine fetches
	a_r_in_fetch: assert property (@(posedge aclk) disable iff (!aresetn)
		r.valid |-> (state == S_FETCH_DATA));

endmodule

`default_nettype wire

/* design/rx_pkg.sv */
`default_nettype none

package rx_pkg;

	//////////////////////////////////////////////////
	// burst channels between engine and descriptor ram
	//////////////////////////////////////////////////

	// read address, len is beats minus one
	typedef struct packed {
		logic [3:0]  id;
		logic [15:0] addr;
		logic [7:0]  len;
		logic        valid;
	} axi_ar_t;

	// write address uses the same layout
	typedef axi_ar_t axi_aw_t;

	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
		logic        valid;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
		logic        valid;
	} axi_w_t;

	typedef struct packed {
		logic [3:0] id;
		logic [1:0] resp;
		logic       valid;
	} axi_b_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	//////////////////////////////////////////////////
	// frame records and frame store channels
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [15:0] length;
		logic [7:0]  errors;
	} frame_rec_t;

	typedef struct packed {
		logic [15:0] buf_addr;
		logic [15:0] buf_len;
	} frm_cmd_t;

	// errors only meaningful with eop
	typedef struct packed {
		logic [15:0] wb_len;
		logic        eop;
		logic [7:0]  errors;
	} frm_rsp_t;

	//////////////////////////////////////////////////
	// legacy rx descriptor, declared msb first
	//////////////////////////////////////////////////

	// dw0 in bits 31:0, dw3 in bits 127:96
	typedef struct packed {
		logic [63:0] rsvd;
		logic [63:0] buf_addr;
	} rx_desc_rd_t;

	typedef struct packed {
		logic [15:0] special;
		logic [7:0]  errors;
		logic [7:0]  status;
		logic [15:0] csum;
		logic [15:0] length;
		logic [63:0] buf_addr;
	} rx_desc_wb_t;

	typedef union packed {
		rx_desc_rd_t rd;
		rx_desc_wb_t wb;
	} rx_desc_u;

	// status report, valid travels with it
	typedef struct packed {
		logic [15:0] desc_addr;
		logic        eop;
		logic        null_buf;
		logic        valid;
	} stat_t;

	// status byte bits
	localparam int STA_DD  = 0;
	localparam int STA_EOP = 1;

endpackage

`default_nettype wire

/* design/rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_top import rx_pkg::*; #(
	parameter int BUF_BYTES   = 2048,
	parameter int DESC_WORDS  = 256,
	parameter int FRAME_DEPTH = 8
) (
	input  wire         aclk,
	input  wire         aresetn,

	input  wire  [15:0] cmd_addr,
	input  wire         cmd_valid,
	output logic        cmd_ready,

	output stat_t       stat,
	input  wire         stat_ready,

	input  frame_rec_t  frame_in,
	input  wire         frame_valid,
	output logic        frame_ready,

	input  wire         host_wr_valid,
	input  wire  [15:0] host_wr_addr,
	input  wire  [31:0] host_wr_data,
	input  wire  [15:0] host_rd_addr,
	output logic [31:0] host_rd_data
);

	// engine to descriptor ram
	axi_ar_t  ar;
	logic     ar_ready;
	axi_r_t   r;
	logic     r_ready;
	axi_aw_t  aw;
	logic     aw_ready;
	axi_w_t   w;
	logic     w_ready;
	axi_b_t   b;
	logic     b_ready;

	// engine to frame store
	frm_cmd_t frm_cmd;
	logic     frm_cmd_valid;
	logic     frm_cmd_ready;
	frm_rsp_t frm_rsp;
	logic     frm_rsp_valid;
	logic     frm_rsp_ready;

	rx_engine #(.BUF_BYTES(BUF_BYTES)) i_rx_engine (
		.aclk, .aresetn,
		.cmd_addr, .cmd_valid, .cmd_ready,
		.stat, .stat_ready,
		.ar, .ar_ready, .r, .r_ready,
		.aw, .aw_ready, .w, .w_ready, .b, .b_ready,
		.frm_cmd, .frm_cmd_valid, .frm_cmd_ready,
		.frm_rsp, .frm_rsp_valid, .frm_rsp_ready
	);

	desc_ram #(.DESC_WORDS(DESC_WORDS)) i_desc_ram (
		.aclk, .aresetn,
		.ar, .ar_ready, .r, .r_ready,
		.aw, .aw_ready, .w, .w_ready, .b, .b_ready,
		.host_wr_valid, .host_wr_addr, .host_wr_data,
		.host_rd_addr, .host_rd_data
	);

	frame_store #(.FRAME_DEPTH(FRAME_DEPTH)) i_frame_store (
		.aclk, .aresetn,
		.frame_in, .frame_valid, .frame_ready,
		.frm_cmd, .frm_cmd_valid, .frm_cmd_ready,
		.frm_rsp, .frm_rsp_valid, .frm_rsp_ready
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the rx descriptor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rx_tb -f sim.f -o rx_sim

# the log decides pass or fail
./obj_dir/rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1

/* sim.f */
design/rx_pkg.sv
design/desc_ram.sv
design/frame_store.sv
design/rx_engine.sv
design/rx_top.sv
verif/rx_tb.sv

/* verif/rx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_tb import rx_pkg::*; ();

	localparam int BUF_BYTES   = 2048;
	localparam int FRAME_DEPTH = 8;
	localparam int NUM_FRAMES  = 14;
	localparam int NUM_SLOTS   = 16;
	localparam int MAX_DESC    = 64;
	localparam int CLK_HALF    = 50;
	localparam logic [31:0] SEED = 32'h539f061b;

	logic        aclk;
	logic        aresetn;
	logic [15:0] cmd_addr;
	logic        cmd_valid;
	logic        cmd_ready;
	stat_t       stat;
	logic        stat_ready;
	frame_rec_t  frame_in;
	logic        frame_valid;
	logic        frame_ready;
	logic        host_wr_valid;
	logic [15:0] host_wr_addr;
	logic [31:0] host_wr_data;
	logic [15:0] host_rd_addr;
	logic [31:0] host_rd_data;

	// frame model in push order
	frame_rec_t  frames [NUM_FRAMES];
	int          fidx;
	logic [15:0] rem;
	int          pushed;
	int          ndesc;

	// separate generators for consumer side and frame gaps
	logic [31:0] rng_main;
	logic [31:0] rng_gap;

	rx_top i_rx_top (
		.aclk, .aresetn,
		.cmd_addr, .cmd_valid, .cmd_ready,
		.stat, .stat_ready,
		.frame_in, .frame_valid, .frame_ready,
		.host_wr_valid, .host_wr_addr, .host_wr_data,
		.host_rd_addr, .host_rd_data
	);

	initial begin
		aclk = 1'b0;
		forever #CLK_HALF aclk = ~aclk;
	end

	// end the run if a descriptor never completes
	initial begin
		repeat (MAX_DESC * 200) @(posedge aclk);
		$display("watchdog expired, descriptor processing did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge aclk);
		host_wr_valid <= 1'b1;
		host_wr_addr  <= addr;
		host_wr_data  <= data;
	endtask

	// one cycle read latency
	task automatic host_read(input logic [15:0] addr, output logic [31:0] data);
		@(posedge aclk);
		host_rd_addr <= addr;
		@(posedge aclk);
		@(negedge aclk);
		data = host_rd_data;
	endtask

	//////////////////////////////////////////////////
	// frame producer
	//////////////////////////////////////////////////

	task automatic push_frames();
		int gap;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			rng_gap = xorshift32(rng_gap);
			gap = int'(rng_gap[1:0]);
			repeat (gap) begin
				@(posedge aclk);
				frame_valid <= 1'b0;
			end
			@(posedge aclk);
			frame_in    <= frames[i];
			frame_valid <= 1'b1;
			@(negedge aclk);
			// ready may only drop with a full queue
			while (!frame_ready) begin
				check_equal("frame_ready", 32'(frame_ready),
					32'((pushed - fidx) < FRAME_DEPTH));
				@(negedge aclk);
			end
			pushed++;
		end
		@(posedge aclk);
		frame_valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// descriptor consumer and model
	//////////////////////////////////////////////////

	task automatic run_descriptor();
		logic [15:0] daddr;
		logic [31:0] dw0;
		logic [31:0] dw1;
		logic [31:0] junk;
		logic [31:0] rd;
		logic        is_null;
		logic        hi_only;
		logic [15:0] exp_len;
		logic        exp_eop;
		logic [7:0]  exp_err;
		logic [7:0]  exp_sta;
		stat_t       exp_stat;
		stat_t       first_stat;
		logic        seen;
		logic        done;

		rng_main = xorshift32(rng_main);
		daddr = 16'((rng_main % NUM_SLOTS) * 16);
		rng_main = xorshift32(rng_main);
		is_null = (rng_main[2:0] == 3'd0);
		// some live buffers have only the upper dword set
		hi_only = !is_null && (rng_main[4:3] == 2'd0);
		rng_main = xorshift32(rng_main);
		dw0 = (is_null || hi_only) ? 32'd0 : (rng_main | 32'h0000_1000);
		rng_main = xorshift32(rng_main);
		dw1 = is_null ? 32'd0 : (rng_main | {31'd0, hi_only});
		rng_main = xorshift32(rng_main);
		junk = rng_main;

		// full buffers until the remainder fits
		exp_eop = 1'b0;
		exp_err = 8'd0;
		if (is_null)
			exp_len = 16'd0;
		else if (rem <= 16'(BUF_BYTES)) begin
			exp_len = rem;
			exp_eop = 1'b1;
			exp_err = frames[fidx].errors;
		end else
			exp_len = 16'(BUF_BYTES);
		exp_sta = 8'd0;
		exp_sta[STA_DD]  = 1'b1;
		exp_sta[STA_EOP] = exp_eop;
		exp_stat = '{desc_addr: daddr, eop: exp_eop, null_buf: is_null, valid: 1'b1};

		// stale write-back words so a missed write shows up
		host_write(daddr, dw0);
		host_write(daddr + 16'd4, dw1);
		host_write(daddr + 16'd8, junk);
		host_write(daddr + 16'd12, ~junk);
		@(posedge aclk);
		host_wr_valid <= 1'b0;

		@(posedge aclk);
		cmd_addr  <= daddr;
		cmd_valid <= 1'b1;
		@(negedge aclk);
		check_equal("cmd_ready", 32'(cmd_ready), 32'd1);
		@(posedge aclk);
		cmd_valid <= 1'b0;

		// random ready gaps on the report
		seen = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(posedge aclk);
			rng_main = xorshift32(rng_main);
			stat_ready <= (rng_main[1:0] != 2'd0);
			@(negedge aclk);
			if (stat.valid) begin
				if (!seen)
					first_stat = stat;
				seen = 1'b1;
				check_equal("stat", {13'd0, stat}, {13'd0, first_stat});
				check_equal("cmd_ready", 32'(cmd_ready), 32'd0);
				done = stat_ready;
			end
		end
		@(posedge aclk);
		stat_ready <= 1'b0;
		check_equal("stat", {13'd0, first_stat}, {13'd0, exp_stat});

		host_read(daddr, rd);
		check_equal("host_rd_data dw0", rd, dw0);
		host_read(daddr + 16'd4, rd);
		check_equal("host_rd_data dw1", rd, dw1);
		host_read(daddr + 16'd8, rd);
		check_equal("host_rd_data dw2", rd, {16'd0, exp_len});
		host_read(daddr + 16'd12, rd);
		check_equal("host_rd_data dw3", rd, {16'd0, exp_err, exp_sta});

		// advance the model
		if (!is_null) begin
			if (exp_eop) begin
				fidx++;
				if (fidx < NUM_FRAMES)
					rem = frames[fidx].length;
			end else
				rem = rem - 16'(BUF_BYTES);
		end
		ndesc++;
	endtask

	task automatic run_descriptors();
		while (fidx < NUM_FRAMES && ndesc < MAX_DESC)
			run_descriptor();
	endtask

	initial begin
		aresetn       = 1'b0;
		cmd_addr      = 16'd0;
		cmd_valid     = 1'b0;
		stat_ready    = 1'b0;
		frame_in      = '0;
		frame_valid   = 1'b0;
		host_wr_valid = 1'b0;
		host_wr_addr  = 16'd0;
		host_wr_data  = 32'd0;
		host_rd_addr  = 16'd0;
		pushed        = 0;
		ndesc         = 0;

		// frames of 1 to 5000 bytes with random error bits
		rng_main = SEED;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			rng_main = xorshift32(rng_main);
			frames[i].length = 16'(rng_main % 5000) + 16'd1;
			rng_main = xorshift32(rng_main);
			frames[i].errors = rng_main[7:0];
		end
		rng_gap = ~rng_main;
		fidx = 0;
		rem  = frames[0].length;

		repeat (2) @(posedge aclk);
		aresetn <= 1'b1;
		@(negedge aclk);
		check_equal("cmd_ready", 32'(cmd_ready), 32'd1);
		check_equal("frame_ready", 32'(frame_ready), 32'd1);
		check_equal("stat.valid", 32'(stat.valid), 32'd0);

		fork
			push_frames();
			run_descriptors();
		join

		if (fidx == NUM_FRAMES) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("descriptor limit reached before all frames were placed");
			$display("TEST FAILED");
			$fatal(1, "frames left over");
		end
	end

endmodule

`default_nettype wire
